// ==== source/eth_rx_params.svh ====
// fixed constants for the 8-bit receive path
// these widths are not meant to be changed per instance
`ifndef ETH_RX_PARAMS_SVH
`define ETH_RX_PARAMS_SVH

// stream byte width
`define ETH_RX_DATA_W 8

// dest mac + src mac + ethertype
`define ETH_RX_HDR_BYTES 14

// dropped-frame counter, saturates at all ones
`define ETH_RX_CNT_W 16

`endif

// ==== source/eth_rx_pkg.sv ====
// types shared by the rx parser, the destination filter and the testbench
// widths come from the params header
`include "eth_rx_params.svh"

package eth_rx_pkg;

    typedef logic [`ETH_RX_DATA_W-1:0] byte_t;
    typedef logic [47:0]               mac_addr_t;
    typedef logic [15:0]               eth_type_t;
    typedef logic [`ETH_RX_CNT_W-1:0]  drop_cnt_t;

    // parser states; the payload states track what sits in the output and skid registers
    typedef enum logic [2:0] {
        RX_IDLE, RX_READ_HEADER, RX_PAYLOAD_IDLE,
        RX_PAYLOAD_XFER, RX_PAYLOAD_WAIT, RX_PAYLOAD_LAST
    } rx_state_t;

    typedef enum logic [1:0] {
        FLT_IDLE, FLT_SEND_HDR, FLT_PASS, FLT_DROP
    } filter_state_t;

endpackage

// ==== source/eth_axis_rx.sv ====
// byte-stream header parser, 8-bit datapath only, no vlan or fcs handling
// a new frame is held off until the previous header has been taken
// tlast inside the 14 header bytes aborts the frame and pulses frame_error
// payload leaves through an output register plus one skid register
`timescale 1ns/1ps
`include "eth_rx_params.svh"

module eth_axis_rx
    import eth_rx_pkg::*;
(
    input  logic      clk,
    input  logic      rst,

    input  byte_t     in_tdata,
    input  logic      in_tvalid,
    output logic      in_tready,
    input  logic      in_tlast,
    input  logic      in_tuser,

    output logic      hdr_valid,
    input  logic      hdr_ready,
    output mac_addr_t dest_mac,
    output mac_addr_t src_mac,
    output eth_type_t eth_type,

    output byte_t     payload_tdata,
    output logic      payload_tvalid,
    input  logic      payload_tready,
    output logic      payload_tlast,
    output logic      payload_tuser,

    output logic      busy,
    output logic      frame_error
);

    rx_state_t  state;
    rx_state_t  state_next;
    logic [3:0] hdr_ptr;
    logic [3:0] hdr_ptr_next;
    logic [2:0] hdr_lane;
    logic       store_hdr;
    logic       in_xfer;

    logic       transfer_in_out;
    logic       transfer_in_temp;
    logic       transfer_temp_out;

    logic       hdr_valid_next;
    logic       frame_error_next;

    // skid register
    byte_t      temp_tdata;
    logic       temp_tlast;
    logic       temp_tuser;

    assign in_xfer = in_tvalid & in_tready;

    // byte lane within the current field, first byte lands most significant
    always_comb begin
        if (hdr_ptr < 4'd6) begin
            hdr_lane = 3'(4'd5 - hdr_ptr);
        end else if (hdr_ptr < 4'd12) begin
            hdr_lane = 3'(4'd11 - hdr_ptr);
        end else begin
            hdr_lane = 3'(4'd13 - hdr_ptr);
        end
    end

    always_comb begin
        state_next        = state;
        hdr_ptr_next      = hdr_ptr;
        store_hdr         = 1'b0;
        transfer_in_out   = 1'b0;
        transfer_in_temp  = 1'b0;
        transfer_temp_out = 1'b0;
        hdr_valid_next    = hdr_valid & ~hdr_ready;
        frame_error_next  = 1'b0;

        case (state)
            RX_IDLE: begin
                if (in_xfer) begin
                    store_hdr = 1'b1;
                    if (in_tlast) begin
                        frame_error_next = 1'b1;
                    end else begin
                        hdr_ptr_next = 4'd1;
                        state_next   = RX_READ_HEADER;
                    end
                end
            end
            RX_READ_HEADER: begin
                if (in_xfer) begin
                    store_hdr    = 1'b1;
                    hdr_ptr_next = hdr_ptr + 4'd1;
                    if (in_tlast) begin
                        // truncated header, drop it
                        hdr_ptr_next     = '0;
                        frame_error_next = 1'b1;
                        state_next       = RX_IDLE;
                    end else if (hdr_ptr == 4'(`ETH_RX_HDR_BYTES - 1)) begin
                        hdr_ptr_next   = '0;
                        hdr_valid_next = 1'b1;
                        state_next     = RX_PAYLOAD_IDLE;
                    end
                end
            end
            RX_PAYLOAD_IDLE: begin
                if (in_xfer) begin
                    transfer_in_out = 1'b1;
                    state_next = in_tlast ? RX_PAYLOAD_LAST : RX_PAYLOAD_XFER;
                end
            end
            RX_PAYLOAD_XFER: begin
                if (in_xfer && payload_tready) begin
                    transfer_in_out = 1'b1;
                    state_next = in_tlast ? RX_PAYLOAD_LAST : RX_PAYLOAD_XFER;
                end else if (payload_tready) begin
                    state_next = RX_PAYLOAD_IDLE;
                end else if (in_xfer) begin
                    // output stalled, park the new byte in the skid register
                    transfer_in_temp = 1'b1;
                    state_next       = RX_PAYLOAD_WAIT;
                end
            end
            RX_PAYLOAD_WAIT: begin
                if (payload_tready) begin
                    transfer_temp_out = 1'b1;
                    state_next = temp_tlast ? RX_PAYLOAD_LAST : RX_PAYLOAD_XFER;
                end
            end
            RX_PAYLOAD_LAST: begin
                if (payload_tready) begin
                    state_next = RX_IDLE;
                end
            end
            default: begin
                state_next = RX_IDLE;
            end
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state          <= RX_IDLE;
            hdr_ptr        <= '0;
            in_tready      <= 1'b0;
            hdr_valid      <= 1'b0;
            payload_tvalid <= 1'b0;
            busy           <= 1'b0;
            frame_error    <= 1'b0;
        end else begin
            state       <= state_next;
            hdr_ptr     <= hdr_ptr_next;
            hdr_valid   <= hdr_valid_next;
            frame_error <= frame_error_next;
            busy        <= (state_next != RX_IDLE);

            // ready and valid follow the state we are heading into
            case (state_next)
                RX_IDLE: begin
                    in_tready      <= ~hdr_valid_next;
                    payload_tvalid <= 1'b0;
                end
                RX_READ_HEADER, RX_PAYLOAD_IDLE: begin
                    in_tready      <= 1'b1;
                    payload_tvalid <= 1'b0;
                end
                RX_PAYLOAD_XFER: begin
                    in_tready      <= 1'b1;
                    payload_tvalid <= 1'b1;
                end
                default: begin
                    // both registers full, or last byte still waiting
                    in_tready      <= 1'b0;
                    payload_tvalid <= 1'b1;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (store_hdr) begin
            if (hdr_ptr < 4'd6) begin
                dest_mac[{hdr_lane, 3'b000} +: `ETH_RX_DATA_W] <= in_tdata;
            end else if (hdr_ptr < 4'd12) begin
                src_mac[{hdr_lane, 3'b000} +: `ETH_RX_DATA_W] <= in_tdata;
            end else begin
                eth_type[{hdr_lane[0], 3'b000} +: `ETH_RX_DATA_W] <= in_tdata;
            end
        end

        if (transfer_in_out) begin
            payload_tdata <= in_tdata;
            payload_tlast <= in_tlast;
            payload_tuser <= in_tuser;
        end else if (transfer_temp_out) begin
            payload_tdata <= temp_tdata;
            payload_tlast <= temp_tlast;
            payload_tuser <= temp_tuser;
        end

        if (transfer_in_temp) begin
            temp_tdata <= in_tdata;
            temp_tlast <= in_tlast;
            temp_tuser <= in_tuser;
        end
    end

endmodule

// ==== source/eth_rx_filter.sv ====
// destination filter behind the header parser
// passes frames to local_mac or broadcast, drains all others
// drop_count saturates, there is no way to clear it short of reset
// expects at least one payload byte per header
`timescale 1ns/1ps

module eth_rx_filter
    import eth_rx_pkg::*;
(
    input  logic      clk,
    input  logic      rst,
    input  mac_addr_t local_mac,

    input  logic      in_hdr_valid,
    output logic      in_hdr_ready,
    input  mac_addr_t in_dest_mac,
    input  mac_addr_t in_src_mac,
    input  eth_type_t in_eth_type,

    input  byte_t     in_payload_tdata,
    input  logic      in_payload_tvalid,
    output logic      in_payload_tready,
    input  logic      in_payload_tlast,
    input  logic      in_payload_tuser,

    output logic      out_hdr_valid,
    input  logic      out_hdr_ready,
    output mac_addr_t out_dest_mac,
    output mac_addr_t out_src_mac,
    output eth_type_t out_eth_type,

    output byte_t     out_payload_tdata,
    output logic      out_payload_tvalid,
    input  logic      out_payload_tready,
    output logic      out_payload_tlast,
    output logic      out_payload_tuser,

    output drop_cnt_t drop_count
);

    filter_state_t state;
    filter_state_t state_next;
    logic          hdr_take;
    logic          addr_match;
    logic          last_xfer;

    assign in_hdr_ready = (state == FLT_IDLE);
    assign hdr_take     = in_hdr_valid & in_hdr_ready;
    assign addr_match   = (in_dest_mac == local_mac) || (in_dest_mac == '1);
    assign last_xfer    = in_payload_tvalid & in_payload_tready & in_payload_tlast;

    assign out_hdr_valid = (state == FLT_SEND_HDR);

    // payload is a straight connection while passing, ready always high while draining
    assign out_payload_tdata  = in_payload_tdata;
    assign out_payload_tlast  = in_payload_tlast;
    assign out_payload_tuser  = in_payload_tuser;
    assign out_payload_tvalid = (state == FLT_PASS) & in_payload_tvalid;
    assign in_payload_tready  = ((state == FLT_PASS) & out_payload_tready) | (state == FLT_DROP);

    always_comb begin
        state_next = state;
        case (state)
            FLT_IDLE: begin
                if (hdr_take) begin
                    state_next = addr_match ? FLT_SEND_HDR : FLT_DROP;
                end
            end
            FLT_SEND_HDR: begin
                if (out_hdr_ready) begin
                    state_next = FLT_PASS;
                end
            end
            FLT_PASS, FLT_DROP: begin
                if (last_xfer) begin
                    state_next = FLT_IDLE;
                end
            end
            default: begin
                state_next = FLT_IDLE;
            end
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state      <= FLT_IDLE;
            drop_count <= '0;
        end else begin
            state <= state_next;
            if ((state == FLT_DROP) && last_xfer && (drop_count != '1)) begin
                drop_count <= drop_count + 1'b1;
            end
        end
    end

    // header copy, held until the sink takes it
    always_ff @(posedge clk) begin
        if (hdr_take) begin
            out_dest_mac <= in_dest_mac;
            out_src_mac  <= in_src_mac;
            out_eth_type <= in_eth_type;
        end
    end

endmodule

// ==== source/eth_rx_top.sv ====
// rx user path: header parser followed by the destination filter
// local_mac is static, change it only between frames
`timescale 1ns/1ps

module eth_rx_top
    import eth_rx_pkg::*;
(
    input  logic      clk,
    input  logic      rst,
    input  mac_addr_t local_mac,

    input  byte_t     in_tdata,
    input  logic      in_tvalid,
    output logic      in_tready,
    input  logic      in_tlast,
    input  logic      in_tuser,

    output logic      hdr_valid,
    input  logic      hdr_ready,
    output mac_addr_t dest_mac,
    output mac_addr_t src_mac,
    output eth_type_t eth_type,

    output byte_t     payload_tdata,
    output logic      payload_tvalid,
    input  logic      payload_tready,
    output logic      payload_tlast,
    output logic      payload_tuser,

    output logic      busy,
    output logic      frame_error,
    output drop_cnt_t drop_count
);

    // parser to filter
    logic      p_hdr_valid;
    logic      p_hdr_ready;
    mac_addr_t p_dest_mac;
    mac_addr_t p_src_mac;
    eth_type_t p_eth_type;
    byte_t     p_payload_tdata;
    logic      p_payload_tvalid;
    logic      p_payload_tready;
    logic      p_payload_tlast;
    logic      p_payload_tuser;

    eth_axis_rx i_parser (
        .clk            (clk),
        .rst            (rst),
        .in_tdata       (in_tdata),
        .in_tvalid      (in_tvalid),
        .in_tready      (in_tready),
        .in_tlast       (in_tlast),
        .in_tuser       (in_tuser),
        .hdr_valid      (p_hdr_valid),
        .hdr_ready      (p_hdr_ready),
        .dest_mac       (p_dest_mac),
        .src_mac        (p_src_mac),
        .eth_type       (p_eth_type),
        .payload_tdata  (p_payload_tdata),
        .payload_tvalid (p_payload_tvalid),
        .payload_tready (p_payload_tready),
        .payload_tlast  (p_payload_tlast),
        .payload_tuser  (p_payload_tuser),
        .busy           (busy),
        .frame_error    (frame_error)
    );

    eth_rx_filter i_filter (
        .clk                (clk),
        .rst                (rst),
        .local_mac          (local_mac),
        .in_hdr_valid       (p_hdr_valid),
        .in_hdr_ready       (p_hdr_ready),
        .in_dest_mac        (p_dest_mac),
        .in_src_mac         (p_src_mac),
        .in_eth_type        (p_eth_type),
        .in_payload_tdata   (p_payload_tdata),
        .in_payload_tvalid  (p_payload_tvalid),
        .in_payload_tready  (p_payload_tready),
        .in_payload_tlast   (p_payload_tlast),
        .in_payload_tuser   (p_payload_tuser),
        .out_hdr_valid      (hdr_valid),
        .out_hdr_ready      (hdr_ready),
        .out_dest_mac       (dest_mac),
        .out_src_mac        (src_mac),
        .out_eth_type       (eth_type),
        .out_payload_tdata  (payload_tdata),
        .out_payload_tvalid (payload_tvalid),
        .out_payload_tready (payload_tready),
        .out_payload_tlast  (payload_tlast),
        .out_payload_tuser  (payload_tuser),
        .drop_count         (drop_count)
    );

endmodule

// ==== tb/tb_eth_rx.sv ====
// directed testbench for eth_rx_top
// one frame in flight at a time
// the sink is always ready unless a test randomizes it
`timescale 1ns/1ps

module tb_eth_rx
    import eth_rx_pkg::*;
();

    localparam int        TIMEOUT   = 2000;
    localparam mac_addr_t LOCAL_MAC = 48'h02_12_34_56_78_9a;
    localparam mac_addr_t OTHER_MAC = 48'h02_00_00_00_00_99;
    localparam mac_addr_t SRC_MAC   = 48'h0a_1b_2c_3d_4e_5f;

    logic      clk;
    logic      rst;
    mac_addr_t local_mac;
    byte_t     in_tdata;
    logic      in_tvalid, in_tready, in_tlast, in_tuser;
    logic      hdr_valid, hdr_ready;
    mac_addr_t dest_mac, src_mac;
    eth_type_t eth_type;
    byte_t     payload_tdata;
    logic      payload_tvalid, payload_tready, payload_tlast, payload_tuser;
    logic      busy, frame_error;
    drop_cnt_t drop_count;

    integer    seed;
    int        errors;
    int        err_mark;
    int        tests_passed;
    int        tests_failed;
    drop_cnt_t exp_drops;

    // frame under test and what came back
    byte_t     tx_bytes[$];
    byte_t     exp_payload[$];
    mac_addr_t exp_dest, exp_src;
    eth_type_t exp_type;
    bit        got_hdr;
    mac_addr_t rx_dest, rx_src;
    eth_type_t rx_type;
    byte_t     rx_payload[$];
    logic      rx_user[$];

    // handshake counts seen at the outputs
    int        hdr_xfers;
    int        payload_xfers;
    int        error_pulses;

    eth_rx_top i_dut (
        .clk            (clk),
        .rst            (rst),
        .local_mac      (local_mac),
        .in_tdata       (in_tdata),
        .in_tvalid      (in_tvalid),
        .in_tready      (in_tready),
        .in_tlast       (in_tlast),
        .in_tuser       (in_tuser),
        .hdr_valid      (hdr_valid),
        .hdr_ready      (hdr_ready),
        .dest_mac       (dest_mac),
        .src_mac        (src_mac),
        .eth_type       (eth_type),
        .payload_tdata  (payload_tdata),
        .payload_tvalid (payload_tvalid),
        .payload_tready (payload_tready),
        .payload_tlast  (payload_tlast),
        .payload_tuser  (payload_tuser),
        .busy           (busy),
        .frame_error    (frame_error),
        .drop_count     (drop_count)
    );

    always #20 clk = ~clk;

    always @(posedge clk) begin
        if (!rst) begin
            if (hdr_valid && hdr_ready) begin
                hdr_xfers++;
            end
            if (payload_tvalid && payload_tready) begin
                payload_xfers++;
                // the parser stays busy until the last byte has left it
                check_flag("busy", 1'b1, busy);
            end
            if (frame_error) begin
                error_pulses++;
            end
        end
    end

    task automatic report_failure(input string msg);
        $display("time %0t: %s", $time, msg);
        errors++;
    endtask

    task automatic check_mac(input string name, input mac_addr_t exp, input mac_addr_t act);
        if (exp !== act) begin
            $display("error: time %0t %s expected %h actual %h", $time, name, exp, act);
            errors++;
        end
    endtask

    task automatic check_type(input string name, input eth_type_t exp, input eth_type_t act);
        if (exp !== act) begin
            $display("error: time %0t %s expected %h actual %h", $time, name, exp, act);
            errors++;
        end
    endtask

    task automatic check_byte(input string name, input byte_t exp, input byte_t act);
        if (exp !== act) begin
            $display("error: time %0t %s expected %h actual %h", $time, name, exp, act);
            errors++;
        end
    endtask

    task automatic check_flag(input string name, input logic exp, input logic act);
        if (exp !== act) begin
            $display("error: time %0t %s expected %b actual %b", $time, name, exp, act);
            errors++;
        end
    endtask

    task automatic check_count(input string name, input drop_cnt_t exp, input drop_cnt_t act);
        if (exp !== act) begin
            $display("error: time %0t %s expected %0d actual %0d", $time, name, exp, act);
            errors++;
        end
    endtask

    task automatic check_total(input string name, input int exp, input int act);
        if (exp != act) begin
            $display("error: time %0t %s expected %0d actual %0d", $time, name, exp, act);
            errors++;
        end
    endtask

    // outputs while rst is still held
    task automatic check_reset_state();
        check_flag("in_tready", 1'b0, in_tready);
        check_flag("hdr_valid", 1'b0, hdr_valid);
        check_flag("payload_tvalid", 1'b0, payload_tvalid);
        check_flag("busy", 1'b0, busy);
        check_flag("frame_error", 1'b0, frame_error);
        check_count("drop_count", '0, drop_count);
    endtask

    // leaves the caller just after a falling edge, where all counters are stable
    task automatic idle_cycles(input int n);
        repeat (n) @(posedge clk);
        @(negedge clk);
    endtask

    // bytes go out as dest, src, ethertype then payload, each field high byte first
    task automatic build_frame(input mac_addr_t dest, input eth_type_t etype,
                               input int len, input bit random_data);
        int i;
        tx_bytes.delete();
        exp_payload.delete();
        for (i = 5; i >= 0; i--) begin
            tx_bytes.push_back(dest[i*8 +: 8]);
        end
        for (i = 5; i >= 0; i--) begin
            tx_bytes.push_back(SRC_MAC[i*8 +: 8]);
        end
        tx_bytes.push_back(etype[15:8]);
        tx_bytes.push_back(etype[7:0]);
        for (i = 0; i < len; i++) begin
            if (random_data) begin
                exp_payload.push_back(byte_t'($random(seed)));
            end else begin
                exp_payload.push_back(byte_t'(8'h40 + 3 * i));
            end
            tx_bytes.push_back(exp_payload[i]);
        end
        exp_dest = dest;
        exp_src  = SRC_MAC;
        exp_type = etype;
    endtask

    task automatic send_frame(input bit user_last);
        int i;
        int wait_cnt;
        for (i = 0; i < tx_bytes.size(); i++) begin
            in_tdata  <= tx_bytes[i];
            in_tvalid <= 1'b1;
            in_tlast  <= (i == tx_bytes.size() - 1);
            in_tuser  <= user_last && (i == tx_bytes.size() - 1);
            wait_cnt = 0;
            @(posedge clk);
            while (!in_tready) begin
                wait_cnt++;
                if (wait_cnt > TIMEOUT) begin
                    report_failure($sformatf("input byte %0d was never accepted", i));
                    in_tvalid <= 1'b0;
                    return;
                end
                @(posedge clk);
            end
        end
        in_tvalid <= 1'b0;
        in_tlast  <= 1'b0;
        in_tuser  <= 1'b0;
    endtask

    task automatic collect_frame(input bit random_ready);
        int wait_cnt;
        bit done;
        rx_payload.delete();
        rx_user.delete();
        got_hdr  = 1'b0;
        done     = 1'b0;
        wait_cnt = 0;
        hdr_ready <= random_ready ? 1'($random(seed)) : 1'b1;
        while (!got_hdr) begin
            @(posedge clk);
            if (hdr_valid && hdr_ready) begin
                got_hdr = 1'b1;
                rx_dest = dest_mac;
                rx_src  = src_mac;
                rx_type = eth_type;
            end else begin
                wait_cnt++;
                if (wait_cnt > TIMEOUT) begin
                    report_failure("no header came out of the DUT");
                    return;
                end
            end
            hdr_ready <= (random_ready && !got_hdr) ? 1'($random(seed)) : 1'b1;
        end
        wait_cnt = 0;
        payload_tready <= random_ready ? 1'($random(seed)) : 1'b1;
        while (!done) begin
            @(posedge clk);
            if (payload_tvalid && payload_tready) begin
                rx_payload.push_back(payload_tdata);
                rx_user.push_back(payload_tuser);
                done     = payload_tlast;
                wait_cnt = 0;
            end else begin
                wait_cnt++;
                if (wait_cnt > TIMEOUT) begin
                    report_failure("payload stopped before a byte with tlast");
                    payload_tready <= 1'b1;
                    return;
                end
            end
            payload_tready <= (random_ready && !done) ? 1'($random(seed)) : 1'b1;
        end
    endtask

    // tlast ends collection, so a matching length also places tlast on the last byte
    task automatic verify_frame(input bit user_last);
        int i;
        if (got_hdr) begin
            check_mac("dest_mac", exp_dest, rx_dest);
            check_mac("src_mac", exp_src, rx_src);
            check_type("eth_type", exp_type, rx_type);
            check_total("payload length", exp_payload.size(), rx_payload.size());
            for (i = 0; i < exp_payload.size() && i < rx_payload.size(); i++) begin
                check_byte($sformatf("payload_tdata[%0d]", i), exp_payload[i], rx_payload[i]);
                check_flag($sformatf("payload_tuser[%0d]", i),
                           user_last && (i == exp_payload.size() - 1), rx_user[i]);
            end
        end
    endtask

    task automatic run_frame(input mac_addr_t dest, input eth_type_t etype, input int len,
                             input bit random_data, input bit user_last, input bit random_ready);
        int hdr_before;
        int pay_before;
        build_frame(dest, etype, len, random_data);
        hdr_before = hdr_xfers;
        pay_before = payload_xfers;
        @(posedge clk);
        fork
            send_frame(user_last);
            collect_frame(random_ready);
        join
        idle_cycles(4);
        verify_frame(user_last);
        check_total("header transfers", hdr_before + 1, hdr_xfers);
        check_total("payload transfers", pay_before + len, payload_xfers);
        // the last byte has left, so the parser is idle again
        check_flag("busy", 1'b0, busy);
    endtask

    task automatic finish_test(input string name);
        if (errors == err_mark) begin
            tests_passed++;
            $display("test %s: pass", name);
        end else begin
            tests_failed++;
            $display("test %s: fail, %0d errors", name, errors - err_mark);
        end
        err_mark = errors;
    endtask

    task automatic test_drop();
        int hdr_before;
        int pay_before;
        int wait_cnt;
        build_frame(OTHER_MAC, 16'h0800, 16, 1'b0);
        exp_drops  = exp_drops + 1'b1;
        hdr_before = hdr_xfers;
        pay_before = payload_xfers;
        wait_cnt   = 0;
        @(posedge clk);
        send_frame(1'b0);
        while (drop_count != exp_drops && wait_cnt <= TIMEOUT) begin
            @(posedge clk);
            wait_cnt++;
        end
        if (wait_cnt > TIMEOUT) begin
            report_failure("drop_count never reached the expected value");
        end
        idle_cycles(4);
        check_count("drop_count", exp_drops, drop_count);
        check_total("header transfers", hdr_before, hdr_xfers);
        check_total("payload transfers", pay_before, payload_xfers);
        run_frame(LOCAL_MAC, 16'h0800, 10, 1'b0, 1'b0, 1'b0);
        finish_test("drop");
    endtask

    task automatic test_truncated();
        int hdr_before;
        int pulses_before;
        int wait_cnt;
        build_frame(LOCAL_MAC, 16'h0800, 10, 1'b0);
        // tlast lands on header byte 9
        while (tx_bytes.size() > 9) begin
            void'(tx_bytes.pop_back());
        end
        hdr_before    = hdr_xfers;
        pulses_before = error_pulses;
        wait_cnt      = 0;
        @(posedge clk);
        send_frame(1'b0);
        while (!frame_error && wait_cnt <= TIMEOUT) begin
            @(posedge clk);
            wait_cnt++;
        end
        if (wait_cnt > TIMEOUT) begin
            report_failure("frame_error never pulsed for the truncated header");
        end
        idle_cycles(4);
        check_total("frame_error cycles", pulses_before + 1, error_pulses);
        check_total("header transfers", hdr_before, hdr_xfers);
        run_frame(LOCAL_MAC, 16'h86dd, 12, 1'b0, 1'b0, 1'b0);
        finish_test("truncated");
    endtask

    initial begin
        seed           = 82;
        errors         = 0;
        err_mark       = 0;
        tests_passed   = 0;
        tests_failed   = 0;
        exp_drops      = '0;
        hdr_xfers      = 0;
        payload_xfers  = 0;
        error_pulses   = 0;
        clk            = 1'b0;
        rst            = 1'b1;
        local_mac      = LOCAL_MAC;
        in_tdata       = '0;
        in_tvalid      = 1'b0;
        in_tlast       = 1'b0;
        in_tuser       = 1'b0;
        hdr_ready      = 1'b1;
        payload_tready = 1'b1;
        repeat (9) @(posedge clk);
        @(negedge clk);
        check_reset_state();
        finish_test("reset");
        @(posedge clk);
        rst <= 1'b0;
        idle_cycles(2);

        run_frame(LOCAL_MAC, 16'h0800, 20, 1'b0, 1'b0, 1'b0);
        finish_test("unicast");
        run_frame('1, 16'h0806, 12, 1'b0, 1'b0, 1'b0);
        finish_test("broadcast");
        test_drop();
        run_frame(LOCAL_MAC, 16'h88b5, 40, 1'b1, 1'b0, 1'b1);
        finish_test("backpressure");
        test_truncated();
        run_frame(LOCAL_MAC, 16'h0800, 8, 1'b0, 1'b1, 1'b0);
        finish_test("tuser");

        $display("tests passed %0d, tests failed %0d", tests_passed, tests_failed);
        if (errors == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

// ==== eth_rx.f ====
+incdir+source
source/eth_rx_pkg.sv
source/eth_axis_rx.sv
source/eth_rx_filter.sv
source/eth_rx_top.sv
tb/tb_eth_rx.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# builds the testbench with Verilator, runs it into a log and judges the log
set -u
cd "$(dirname "$0")"

BUILD_DIR=obj_dir
LOG=sim.log

verilator --binary --timing -Wno-fatal --top-module tb_eth_rx \
    -f eth_rx.f -Mdir "$BUILD_DIR" -o sim_eth_rx
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

"./$BUILD_DIR/sim_eth_rx" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "ALL CHECKS PASSED" "$LOG"; then
    echo "result: pass"
    exit 0
fi
echo "result: fail"
exit 1
